//--- common/eclock_defs.svh
// ========================================
// Elink clock generator sizing
// Buffer depth, serializer word width and
// settings synchronizer length
// ========================================

`ifndef ECLOCK_DEFS_SVH
`define ECLOCK_DEFS_SVH

// Entries per lane buffer, also full credit count
`define ECLK_FIFO_DEPTH 4

// Parallel word handed to the 8:1 serializer
`define ECLK_WORD_W 8

// Flops between the config register and the pattern logic
`define ECLK_SYNC_STAGES 2

`endif

//--- common/eclock_pkg.sv
// ========================================
// Elink clock generator types
// Divide codes, lane payloads and the
// fixed serializer patterns
// ========================================

`include "eclock_defs.svh"

package eclock_pkg;

   typedef logic [3:0] div_code_t;                    // Per-lane settings nibble

   localparam div_code_t CODE_OFF  = 4'h0;            // Clock off
   localparam div_code_t CODE_DIV1 = 4'h7;            // Divide by 1
   localparam div_code_t CODE_DIV2 = 4'h6;            // Divide by 2
   localparam div_code_t CODE_DIV4 = 4'h5;            // Divide by 4, others are /8

   typedef logic [`ECLK_WORD_W-1:0] cclk_word_t;      // Core clock lane word

   typedef struct packed {
      logic [`ECLK_WORD_W-1:0] word;                  // In-phase link clock
      logic [`ECLK_WORD_W-1:0] word90;                // Quarter period later
   } lclk_word_t;

   localparam logic [`ECLK_WORD_W-1:0] PAT_DIV1    = 8'hAA;
   localparam logic [`ECLK_WORD_W-1:0] PAT_DIV2    = 8'hCC;
   localparam logic [`ECLK_WORD_W-1:0] PAT_DIV4    = 8'hF0;
   // Quarter period later, one bit for /2 and two bits for /4
   localparam logic [`ECLK_WORD_W-1:0] PAT_DIV2_90 = 8'h66;
   localparam logic [`ECLK_WORD_W-1:0] PAT_DIV4_90 = 8'h3C;

endpackage

//--- common/credit_if.sv
// ========================================
// Credit controlled push channel
// Producer pushes words against credits,
// buffer returns one credit per pop
// ========================================

interface credit_if #(
   parameter type payload_t = logic [7:0]
) ();

   logic     valid;                                   // One push this cycle
   payload_t payload;                                 // Word being pushed
   logic     credit;                                  // One slot freed
   logic     flush;                                   // Drop everything buffered

   modport producer (
      output valid,
      output payload,
      output flush,
      input  credit
   );

   modport buffer (
      input  valid,
      input  payload,
      input  flush,
      output credit
   );

endinterface

//--- pattern_gen/pattern_gen.sv
// ========================================
// Clock pattern generator
// Synchronizes the clock settings and
// pushes one serializer word per lane per
// cycle while credits remain
// ========================================

`include "eclock_defs.svh"

module pattern_gen (
   input  logic        cclk_div,
   input  logic        rst,
   input  logic [15:0] ecfg_clk_settings,
   credit_if.producer  cclk_ch,
   credit_if.producer  lclk_ch
);

   localparam int CNT_W = $clog2(`ECLK_FIFO_DEPTH + 1);

   logic [7:0]              sync_q [`ECLK_SYNC_STAGES];  // Settings synchronizer
   eclock_pkg::div_code_t   c_code;                      // Active core clock code
   eclock_pkg::div_code_t   l_code;                      // Active link clock code
   eclock_pkg::div_code_t   c_sync;
   eclock_pkg::div_code_t   l_sync;
   eclock_pkg::div_code_t   l_eff;                       // Link code, /1 folded to /2
   logic                    flush_q;
   logic [CNT_W-1:0]        credit_cnt;                  // Shared by both lanes
   logic                    credit_in;
   logic                    phase;                       // High means next /8 word is FF
   logic [`ECLK_WORD_W-1:0] l_prev;                      // Last pushed link word
   logic                    change;
   logic                    push;
   eclock_pkg::cclk_word_t  c_word;
   eclock_pkg::lclk_word_t  l_word;

   function automatic logic [`ECLK_WORD_W-1:0] base_word(eclock_pkg::div_code_t code,
                                                         logic ph);
      case (code)
         eclock_pkg::CODE_OFF:  return '0;
         eclock_pkg::CODE_DIV1: return eclock_pkg::PAT_DIV1;
         eclock_pkg::CODE_DIV2: return eclock_pkg::PAT_DIV2;
         eclock_pkg::CODE_DIV4: return eclock_pkg::PAT_DIV4;
         default:               return ph ? '1 : '0;     // Slow clock, whole word toggles
      endcase
   endfunction

   assign c_sync    = sync_q[`ECLK_SYNC_STAGES-1][3:0];
   assign l_sync    = sync_q[`ECLK_SYNC_STAGES-1][7:4];
   assign change    = (c_sync != c_code) || (l_sync != l_code);
   assign push      = (credit_cnt != '0) && !flush_q;   // Nothing goes in during flush
   assign credit_in = cclk_ch.credit & lclk_ch.credit;   // Lanes pop in lockstep
   assign l_eff     = (l_code == eclock_pkg::CODE_DIV1) ? eclock_pkg::CODE_DIV2 : l_code;
   assign c_word    = base_word(c_code, phase);

   always_comb begin
      l_word.word = base_word(l_eff, phase);
      case (l_eff)
         eclock_pkg::CODE_OFF:  l_word.word90 = '0;
         eclock_pkg::CODE_DIV2: l_word.word90 = eclock_pkg::PAT_DIV2_90;
         eclock_pkg::CODE_DIV4: l_word.word90 = eclock_pkg::PAT_DIV4_90;
         default:               l_word.word90 = {l_prev[3:0], l_word.word[7:4]};
      endcase
   end

   always_ff @(posedge cclk_div) begin
      if (rst) begin
         for (int i = 0; i < `ECLK_SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
         c_code     <= eclock_pkg::CODE_OFF;
         l_code     <= eclock_pkg::CODE_OFF;
         flush_q    <= 1'b0;
         credit_cnt <= CNT_W'(`ECLK_FIFO_DEPTH);
         phase      <= 1'b1;
         l_prev     <= '0;
      end else begin
         sync_q[0] <= ecfg_clk_settings[7:0];          // Upper byte not used here
         for (int i = 1; i < `ECLK_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         flush_q <= change;
         if (flush_q) begin
            credit_cnt <= CNT_W'(`ECLK_FIFO_DEPTH);     // Buffers are empty again
         end else begin
            credit_cnt <= credit_cnt - CNT_W'(push) + CNT_W'(credit_in);
         end
         if (change) begin
            c_code <= c_sync;
            l_code <= l_sync;
            phase  <= 1'b1;                             // New sequence starts at FF
            l_prev <= '0;
         end else if (push) begin
            phase  <= ~phase;
            l_prev <= l_word.word;
         end
      end
   end

   assign cclk_ch.valid   = push;
   assign cclk_ch.payload = c_word;
   assign cclk_ch.flush   = flush_q;
   assign lclk_ch.valid   = push;
   assign lclk_ch.payload = l_word;
   assign lclk_ch.flush   = flush_q;

endmodule

//--- source/pattern_fifo.sv
// ========================================
// Lane word buffer
// Circular buffer that returns a credit
// per pop and empties on flush
// ========================================

`include "eclock_defs.svh"

module pattern_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     cclk_div,
   input  logic     rst,
   credit_if.buffer wr,
   output logic     rd_valid,
   output payload_t rd_data,
   input  logic     rd_pop
);

   localparam int DEPTH = `ECLK_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];                      // Word storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                            // Entries held
   logic             do_pop;
   logic             credit_q;

   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign rd_valid  = (count != '0) && !wr.flush;      // Flush cycle reads as empty
   assign rd_data   = mem[rd_ptr];
   assign do_pop    = rd_pop && rd_valid;
   assign wr.credit = credit_q && !wr.flush;           // No credit while flushing

   always_ff @(posedge cclk_div) begin
      if (wr.valid && !wr.flush) begin
         mem[wr_ptr] <= wr.payload;
      end
   end

   always_ff @(posedge cclk_div) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_q <= 1'b0;
      end else if (wr.flush) begin
         wr_ptr   <= '0;                               // Discard all entries
         rd_ptr   <= '0;
         count    <= '0;
         credit_q <= 1'b0;
      end else begin
         credit_q <= do_pop;                           // Credit trails pop by a cycle
         if (wr.valid) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CNT_W'(wr.valid) - CNT_W'(do_pop);
      end
   end

endmodule

//--- source/serdes_feed.sv
// ========================================
// Serializer feeder
// Pops both lanes together when the
// serializer asks for a word and holds
// the words in output registers
// ========================================

module serdes_feed (
   input  logic                   cclk_div,
   input  logic                   rst,
   input  logic                   ser_ready,
   input  logic                   c_valid,
   input  eclock_pkg::cclk_word_t c_data,
   output logic                   c_pop,
   input  logic                   l_valid,
   input  eclock_pkg::lclk_word_t l_data,
   output logic                   l_pop,
   output logic                   word_valid,
   output logic [7:0]             cclk_word,
   output logic [7:0]             lclk_word,
   output logic [7:0]             lclk90_word
);

   logic pop;

   // Both lanes must have a word, else neither moves
   assign pop   = ser_ready && c_valid && l_valid;
   assign c_pop = pop;
   assign l_pop = pop;

   always_ff @(posedge cclk_div) begin
      if (rst) begin
         word_valid  <= 1'b0;
         cclk_word   <= '0;
         lclk_word   <= '0;
         lclk90_word <= '0;
      end else begin
         word_valid <= pop;
         if (pop) begin
            cclk_word   <= c_data;
            lclk_word   <= l_data.word;
            lclk90_word <= l_data.word90;
         end else begin
            cclk_word   <= '0;                         // Idle serializer sees low
            lclk_word   <= '0;
            lclk90_word <= '0;
         end
      end
   end

endmodule

//--- source/eclock_gen.sv
// ========================================
// Elink clock generator pattern path
// Pattern generator, two lane buffers
// and the serializer feeder
// ========================================

module eclock_gen (
   input  logic        cclk_div,
   input  logic        rst,
   input  logic [15:0] ecfg_clk_settings,
   input  logic        ser_ready,
   output logic        word_valid,
   output logic [7:0]  cclk_word,
   output logic [7:0]  lclk_word,
   output logic [7:0]  lclk90_word
);

   eclock_pkg::cclk_word_t c_data;                     // Core lane buffer head
   eclock_pkg::lclk_word_t l_data;                     // Link lane buffer head
   logic                   c_valid;
   logic                   l_valid;
   logic                   c_pop;
   logic                   l_pop;

   credit_if #(.payload_t(eclock_pkg::cclk_word_t)) cclk_ch ();
   credit_if #(.payload_t(eclock_pkg::lclk_word_t)) lclk_ch ();

   pattern_gen u_pattern_gen (
      .cclk_div          (cclk_div),
      .rst               (rst),
      .ecfg_clk_settings (ecfg_clk_settings),
      .cclk_ch           (cclk_ch),
      .lclk_ch           (lclk_ch)
   );

   pattern_fifo #(.payload_t(eclock_pkg::cclk_word_t)) u_cclk_fifo (
      .cclk_div (cclk_div),
      .rst      (rst),
      .wr       (cclk_ch),
      .rd_valid (c_valid),
      .rd_data  (c_data),
      .rd_pop   (c_pop)
   );

   pattern_fifo #(.payload_t(eclock_pkg::lclk_word_t)) u_lclk_fifo (
      .cclk_div (cclk_div),
      .rst      (rst),
      .wr       (lclk_ch),
      .rd_valid (l_valid),
      .rd_data  (l_data),
      .rd_pop   (l_pop)
   );

   serdes_feed u_serdes_feed (
      .cclk_div    (cclk_div),
      .rst         (rst),
      .ser_ready   (ser_ready),
      .c_valid     (c_valid),
      .c_data      (c_data),
      .c_pop       (c_pop),
      .l_valid     (l_valid),
      .l_data      (l_data),
      .l_pop       (l_pop),
      .word_valid  (word_valid),
      .cclk_word   (cclk_word),
      .lclk_word   (lclk_word),
      .lclk90_word (lclk90_word)
   );

endmodule

//--- tests/eclock_clk.sv
// ========================================
// Testbench clock and reset
// 4 ns cclk_div, reset held for the
// first few rising edges
// ========================================

module eclock_clk #(
   parameter int RST_CYCLES = 5
) (
   output logic cclk_div,
   output logic rst
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      cclk_div = 1'b0;
      forever #2 cclk_div = ~cclk_div;                 // 4 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge cclk_div);
      #1 rst = 1'b0;                                   // Released at input drive time
   end

endmodule

//--- tests/eclock_tb.sv
// ========================================
// Elink clock generator testbench
// Random lane codes and serializer pacing,
// output words checked against a model
// ========================================

`include "eclock_defs.svh"

module eclock_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_SEGS       = 12;
   localparam int SEG_CYCLES     = 150;
   localparam int TIMEOUT_CYCLES = NUM_SEGS * SEG_CYCLES + 200;
   localparam int OLD_WINDOW     = `ECLK_SYNC_STAGES + 1;  // Latest old word after a change

   logic        cclk_div;
   logic        rst;
   logic [15:0] ecfg_clk_settings;
   logic        ser_ready;
   logic        word_valid;
   logic [7:0]  cclk_word;
   logic [7:0]  lclk_word;
   logic [7:0]  lclk90_word;

   logic [31:0] rng;                                   // Xorshift state
   int          cycle;
   int          wd_cycles;
   int          change_cycle;                          // Cycle the new codes were driven
   logic        pending;                               // New stream not seen yet
   logic [3:0]  cur_c;                                 // Codes of the stream on the outputs
   logic [3:0]  cur_l;
   logic [3:0]  new_c;
   logic [3:0]  new_l;
   logic        cur_ph;                                // High means next /8 word is FF
   logic [7:0]  cur_prev;                              // Last link word of the stream

   eclock_clk u_clk (
      .cclk_div (cclk_div),
      .rst      (rst)
   );

   eclock_gen dut (
      .cclk_div          (cclk_div),
      .rst               (rst),
      .ecfg_clk_settings (ecfg_clk_settings),
      .ser_ready         (ser_ready),
      .word_valid        (word_valid),
      .cclk_word         (cclk_word),
      .lclk_word         (lclk_word),
      .lclk90_word       (lclk90_word)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Fixed patterns and off picked often, any nibble otherwise
   function automatic logic [3:0] pick_code(input logic [31:0] r);
      case (r[2:0])
         3'd0:    return 4'h0;
         3'd1:    return 4'h7;
         3'd2:    return 4'h6;
         3'd3:    return 4'h5;
         default: return r[11:8];
      endcase
   endfunction

   function automatic logic [7:0] lane_word(input logic [3:0] code, input logic ph);
      case (code)
         4'h0:    return 8'h00;
         4'h7:    return 8'hAA;
         4'h6:    return 8'hCC;
         4'h5:    return 8'hF0;
         default: return ph ? 8'hFF : 8'h00;           // Divide by 8 toggle
      endcase
   endfunction

   // Link word a quarter period later
   function automatic logic [7:0] quarter_word(input logic [3:0] code,
                                               input logic [7:0] word,
                                               input logic [7:0] prev);
      case (code)
         4'h0:    return 8'h00;
         4'h6:    return 8'h66;
         4'h5:    return 8'h3C;
         default: return {prev[3:0], word[7:4]};
      endcase
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic model_words(output logic [7:0] c_exp, output logic [7:0] l_exp,
                              output logic [7:0] l90_exp);
      logic [3:0] l_eff;
      l_eff   = (cur_l == 4'h7) ? 4'h6 : cur_l;         // Link lane has no divide by 1
      c_exp   = lane_word(cur_c, cur_ph);
      l_exp   = lane_word(l_eff, cur_ph);
      l90_exp = quarter_word(l_eff, l_exp, cur_prev);
   endtask

   task automatic check_word();
      logic [7:0] c_exp;
      logic [7:0] l_exp;
      logic [7:0] l90_exp;
      logic       old_ok;
      if (!word_valid) begin
         assert ({cclk_word, lclk_word, lclk90_word} == 24'h0) else
            fail_run($sformatf("Error: idle cclk_word %h lclk_word %h lclk90_word %h, expected 00",
                               cclk_word, lclk_word, lclk90_word));
      end else begin
         if (pending) begin
            model_words(c_exp, l_exp, l90_exp);
            old_ok = (cycle <= change_cycle + OLD_WINDOW) && (cclk_word == c_exp) &&
                     (lclk_word == l_exp) && (lclk90_word == l90_exp);
            if (!old_ok) begin
               cur_c    = new_c;                       // Must be the new stream's first word
               cur_l    = new_l;
               cur_ph   = 1'b1;
               cur_prev = 8'h00;
               pending  = 1'b0;
            end
         end
         model_words(c_exp, l_exp, l90_exp);
         assert (cclk_word == c_exp) else
            fail_run($sformatf("Error: cclk_word expected %h got %h", c_exp, cclk_word));
         assert (lclk_word == l_exp) else
            fail_run($sformatf("Error: lclk_word expected %h got %h", l_exp, lclk_word));
         assert (lclk90_word == l90_exp) else
            fail_run($sformatf("Error: lclk90_word expected %h got %h", l90_exp, lclk90_word));
         cur_ph   = ~cur_ph;
         cur_prev = l_exp;
      end
   endtask

   task automatic start_segment(input int seg);
      logic [3:0] c;
      logic [3:0] l;
      if (pending) begin
         fail_run("No words with the new clock codes appeared within the segment");
      end
      rng = xorshift32(rng);
      c   = pick_code(rng);
      rng = xorshift32(rng);
      l   = pick_code(rng);
      if (seg == NUM_SEGS / 2) begin
         c = 4'h0;                                     // Both lanes off
         l = 4'h0;
      end
      ecfg_clk_settings = {rng[23:16], l, c};          // Upper byte has no effect
      if ({l, c} != {cur_l, cur_c}) begin
         new_c        = c;
         new_l        = l;
         pending      = 1'b1;
         change_cycle = cycle;
      end
   endtask

   initial begin : watchdog
      wd_cycles = 0;
      forever begin
         @(posedge cclk_div);
         wd_cycles++;
         if (wd_cycles > TIMEOUT_CYCLES) begin
            fail_run("Timeout: the run did not end within the cycle limit");
         end
      end
   end

   initial begin : stimulus
      ecfg_clk_settings = '0;
      ser_ready         = 1'b0;
      rng               = 32'he1d7_bf70;
      cycle             = 0;
      change_cycle      = 0;
      pending           = 1'b0;
      cur_c             = 4'h0;                        // Reset state of the DUT
      cur_l             = 4'h0;
      new_c             = 4'h0;
      new_l             = 4'h0;
      cur_ph            = 1'b1;
      cur_prev          = 8'h00;
      @(negedge rst);
      for (int seg = 0; seg < NUM_SEGS; seg++) begin
         start_segment(seg);
         for (int i = 0; i < SEG_CYCLES; i++) begin
            rng       = xorshift32(rng);
            ser_ready = (rng % 10) < 6;                // About 60 percent ready
            @(posedge cclk_div);
            #1;
            cycle++;
            check_word();
         end
      end
      if (pending) begin
         fail_run("No words with the new clock codes appeared in the last segment");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

//--- eclock_gen.f
+incdir+common
common/eclock_pkg.sv
common/credit_if.sv
pattern_gen/pattern_gen.sv
source/pattern_fifo.sv
source/serdes_feed.sv
source/eclock_gen.sv
tests/eclock_clk.sv
tests/eclock_tb.sv

//--- Bender.yml
package:
  name: eclock_gen

sources:
  - include_dirs:
      - common
    files:
      - common/eclock_pkg.sv
      - common/credit_if.sv
      - pattern_gen/pattern_gen.sv
      - source/pattern_fifo.sv
      - source/serdes_feed.sv
      - source/eclock_gen.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/eclock_clk.sv
      - tests/eclock_tb.sv
